// File: life_engine.f
source/life_geometry_pkg.sv
source/life_control_pkg.sv
source/step_control.sv
source/window_fetcher.sv
source/cell_rule_array.sv
source/word_packer.sv
source/life_engine.sv
tb/life_checker.sv
tb/life_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the life engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f life_engine.f \
    --top-module life_engine_tb -o sim_life_engine
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_life_engine > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    echo "no result found in sim.log"
    exit 1
fi
exit 0

// File: tb/life_engine_tb.sv
`timescale 1ns/10ps

module life_engine_tb
    import life_geometry_pkg::*;
    import life_control_pkg::*;
();

    localparam int NUM_TESTS = 10;
    localparam int K_BLINK   = 0;
    localparam int K_GLIDER  = 1;
    localparam int K_BORDER  = 2;
    localparam int K_RANDOM  = 3;

    typedef struct packed {
        logic [8*12-1:0] name;
        logic [1:0]      kind;        // board pattern
        speed_t          speed;
        cursor_t         cursor;
        logic            exp_evolve;  // worked out by hand from the accumulator rule
    } test_t;

    logic       clk_in;
    logic       rst_in;
    logic       start_in;
    speed_t     speed_in;
    cursor_t    cursor_in;
    word_t      data_r_in;
    addr_t      addr_r_out;
    mem_write_t write_out;
    logic       done_out;

    test_t                         tests [NUM_TESTS];
    word_t                         mem [MAX_ADDR];
    word_t                         rd_word;
    logic [MAX_ADDR*WORD_SIZE-1:0] board_flat;
    logic [8*12-1:0]               test_name;
    logic                          pred_evolve;
    speed_t                        accum;  // model of the engine's accumulator
    int                            seed = 46524;
    int                            judged;
    int                            failed;
    int                            tb_errors;

    life_engine DUT (.*);

    life_checker life_checker (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .start_in   (start_in),
        .done_out   (done_out),
        .write_out  (write_out),
        .board      (board_flat),
        .exp_evolve (pred_evolve),
        .cursor_in  (cursor_in),
        .test_name  (test_name),
        .judged     (judged),
        .failed     (failed)
    );

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = !clk_in;
    end

    // one cycle read latency
    always @(posedge clk_in) begin
        rd_word = mem[addr_r_out];
        #2 data_r_in = rd_word;
    end

    task automatic set_cell(input int x, input int y);
        mem[y*WORDS_PER_ROW + x/WORD_SIZE][WORD_SIZE-1 - x%WORD_SIZE] = 1'b1;
    endtask

    task automatic load_board(input logic [1:0] kind);
        for (int a = 0; a < MAX_ADDR; a++) begin
            mem[a] = (kind == 2'(K_RANDOM)) ? word_t'($random(seed)) : '0;
        end
        if (kind == 2'(K_BLINK)) begin
            set_cell(7, 3);  // crosses the word boundary
            set_cell(8, 3);
            set_cell(9, 3);
            set_cell(0, 14);
            set_cell(0, 15);
            set_cell(1, 15);
        end else if (kind == 2'(K_GLIDER)) begin
            set_cell(1, 1);
            set_cell(2, 2);
            set_cell(0, 3);
            set_cell(1, 3);
            set_cell(2, 3);
        end else if (kind == 2'(K_BORDER)) begin
            for (int i = 0; i < BOARD_SIZE; i++) begin
                set_cell(i, 0);
                set_cell(i, BOARD_SIZE - 1);
                set_cell(0, i);
                set_cell(BOARD_SIZE - 1, i);
            end
        end
        for (int a = 0; a < MAX_ADDR; a++) begin
            board_flat[a*WORD_SIZE +: WORD_SIZE] = mem[a];
        end
    endtask

    initial begin
        #(NUM_TESTS * 40 * 20 * 20);
        $display("watchdog expired before all tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst_in      = 1'b1;
        start_in    = 1'b0;
        speed_in    = '0;
        cursor_in   = '0;
        data_r_in   = '0;
        accum       = '0;
        pred_evolve = 1'b0;
        test_name   = '0;
        board_flat  = '0;
        tb_errors   = 0;
        tests[0] = '{"blinker", 2'(K_BLINK), 8'd255, '0, 1'b1};
        tests[1] = '{"glider", 2'(K_GLIDER), 8'd255, '0, 1'b1};
        tests[2] = '{"random_evo", 2'(K_RANDOM), 8'd255, '0, 1'b1};
        tests[3] = '{"border", 2'(K_BORDER), 8'd255, '0, 1'b1};
        tests[4] = '{"copy_spd0", 2'(K_RANDOM), 8'd0, '0, 1'b0};
        tests[5] = '{"half_a", 2'(K_RANDOM), 8'd128, '0, 1'b1};
        tests[6] = '{"half_b", 2'(K_RANDOM), 8'd128, '0, 1'b0};
        tests[7] = '{"half_c", 2'(K_RANDOM), 8'd128, '0, 1'b1};
        tests[8] = '{"click_evo", 2'(K_GLIDER), 8'd255, '{4'd4, 4'd5, 1'b1}, 1'b1};
        tests[9] = '{"click_copy", 2'(K_RANDOM), 8'd0, '{4'd15, 4'd0, 1'b1}, 1'b0};
        repeat (8) @(posedge clk_in);
        #2 rst_in = 1'b0;
        repeat (3) @(posedge clk_in);
        #2;
        if (!done_out) begin
            $display("done_out is low after reset");
            tb_errors++;
        end
        for (int i = 0; i < NUM_TESTS; i++) begin
            load_board(tests[i].kind);
            pred_evolve = accum >= 8'd255 - tests[i].speed;
            accum       = accum + tests[i].speed;
            if (pred_evolve != tests[i].exp_evolve) begin
                $display("accumulator model disagrees with the table in test %0d", i);
                tb_errors++;
            end
            test_name = tests[i].name;
            speed_in  = tests[i].speed;
            cursor_in = tests[i].cursor;
            @(posedge clk_in);
            #2 start_in = 1'b1;
            @(posedge clk_in);
            #2 start_in = 1'b0;
            while (judged != i + 1) begin
                @(posedge clk_in);
                #2;
            end
        end
        repeat (4) @(posedge clk_in);
        $display("tests %0d, failed %0d, other errors %0d", judged, failed, tb_errors);
        if (failed == 0 && tb_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tb/life_checker.sv
`timescale 1ns/10ps

module life_checker
    import life_geometry_pkg::*;
    import life_control_pkg::*;
(
    input  logic                            clk_in,
    input  logic                            rst_in,
    input  logic                            start_in,
    input  logic                            done_out,
    input  mem_write_t                      write_out,
    input  logic [MAX_ADDR*WORD_SIZE-1:0]   board,      // word a at bits a*WORD_SIZE
    input  logic                            exp_evolve,
    input  cursor_t                         cursor_in,
    input  logic [8*12-1:0]                 test_name,
    output int                              judged,
    output int                              failed
);

    word_t got [MAX_ADDR];
    int    wr_count;
    logic  active;         // a pass is running
    logic  pending_start;  // start was accepted on the last edge
    logic  done_q;
    logic  bad;

    // cells beyond the board are dead
    function automatic logic cell_at(input logic [MAX_ADDR*WORD_SIZE-1:0] b,
                                     input int x, input int y);
        if (x < 0 || y < 0 || x >= BOARD_SIZE || y >= BOARD_SIZE) begin
            return 1'b0;
        end
        return b[(y*WORDS_PER_ROW + x/WORD_SIZE)*WORD_SIZE + WORD_SIZE-1 - x%WORD_SIZE];
    endfunction

    function automatic word_t next_word(input logic [MAX_ADDR*WORD_SIZE-1:0] b,
                                        input logic ev, input cursor_t cur, input int a);
        word_t w;
        int    x;
        int    y;
        int    n;
        logic  old;
        y = a / WORDS_PER_ROW;
        for (int k = 0; k < WORD_SIZE; k++) begin
            x   = (a % WORDS_PER_ROW) * WORD_SIZE + k;
            old = cell_at(b, x, y);
            n   = 0;
            for (int dy = -1; dy <= 1; dy++) begin
                for (int dx = -1; dx <= 1; dx++) begin
                    if (dx != 0 || dy != 0) begin
                        n += int'(cell_at(b, x + dx, y + dy));
                    end
                end
            end
            if (cur.click && x == int'(cur.x) && y == int'(cur.y)) begin
                w[WORD_SIZE-1-k] = !old;
            end else if (!ev) begin
                w[WORD_SIZE-1-k] = old;
            end else begin
                w[WORD_SIZE-1-k] = old ? (n == 2 || n == 3) : (n == 3);
            end
        end
        return w;
    endfunction

    always @(posedge clk_in) begin
        if (rst_in) begin
            active        = 1'b0;
            pending_start = 1'b0;
            done_q        = 1'b1;
            wr_count      = 0;
            judged        = 0;
            failed        = 0;
        end else begin
            if (pending_start && done_out) begin
                $display("[FAIL] %0s done_out one cycle after start expected 0 actual 1",
                         test_name);
                bad = 1'b1;
            end
            pending_start = start_in && done_out;
            if (start_in && done_out) begin
                active   = 1'b1;
                wr_count = 0;
                bad      = 1'b0;
            end
            if (write_out.wr_en) begin
                if (!active) begin
                    $display("a memory write happened while no pass was running");
                    failed++;
                end else if (int'(write_out.addr) != wr_count) begin
                    $display("[FAIL] %0s write address expected %0d actual %0d", test_name,
                             wr_count, write_out.addr);
                    bad = 1'b1;
                    wr_count++;
                end else begin
                    got[write_out.addr] = write_out.data;
                    wr_count++;
                end
            end
            if (done_out && !done_q && active) begin
                if (wr_count != MAX_ADDR) begin
                    $display("[FAIL] %0s words written expected %0d actual %0d", test_name,
                             MAX_ADDR, wr_count);
                    bad = 1'b1;
                end
                for (int a = 0; a < MAX_ADDR; a++) begin
                    if (!bad && got[a] !== next_word(board, exp_evolve, cursor_in, a)) begin
                        $display("[FAIL] %0s word %0d expected %h actual %h", test_name, a,
                                 next_word(board, exp_evolve, cursor_in, a), got[a]);
                        bad = 1'b1;
                    end
                end
                if (bad) begin
                    failed++;
                end else begin
                    $display("[PASS] %0s", test_name);
                end
                judged++;
                active = 1'b0;
            end
            done_q = done_out;
        end
    end

endmodule

// File: source/life_engine.sv
`timescale 1ns/10ps

module life_engine
    import life_geometry_pkg::*;
    import life_control_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       start_in,
    input  speed_t     speed_in,
    input  cursor_t    cursor_in,
    input  word_t      data_r_in,
    output addr_t      addr_r_out,
    output mem_write_t write_out,
    output logic       done_out
);

    logic        evolve;
    logic        wb_start;
    logic        pack_done;
    fetch_item_t item;
    logic        stall;
    logic        fetch_done;
    cells_t      cells;
    logic        rule_stall;
    logic        rule_done;

    step_control u_step_control (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .start_in  (start_in),
        .speed_in  (speed_in),
        .pack_done (pack_done),
        .evolve    (evolve),
        .wb_start  (wb_start),
        .done_out  (done_out)
    );

    window_fetcher u_window_fetcher (
        .clk_in     (clk_in),
        .start_in   (start_in),
        .data_r_in  (data_r_in),
        .addr_r_out (addr_r_out),
        .item       (item),
        .stall      (stall),
        .fetch_done (fetch_done)
    );

    cell_rule_array u_cell_rule_array (
        .clk_in     (clk_in),
        .item       (item),
        .stall      (stall),
        .fetch_done (fetch_done),
        .evolve     (evolve),
        .cursor_in  (cursor_in),
        .cells      (cells),
        .rule_stall (rule_stall),
        .rule_done  (rule_done)
    );

    word_packer u_word_packer (
        .clk_in     (clk_in),
        .wb_start   (wb_start),
        .cells      (cells),
        .rule_stall (rule_stall),
        .rule_done  (rule_done),
        .write_out  (write_out),
        .pack_done  (pack_done)
    );

endmodule

// File: source/word_packer.sv
`timescale 1ns/10ps

module word_packer
    import life_geometry_pkg::*;
    import life_control_pkg::*;
(
    input  logic       clk_in,
    input  logic       wb_start,
    input  cells_t     cells,
    input  logic       rule_stall,
    input  logic       rule_done,
    output mem_write_t write_out,
    output logic       pack_done
);

    logic [LOG_WORD_SIZE-1:0] fill;  // cells already shifted into the word

    always_ff @(posedge clk_in) begin
        if (wb_start) begin
            fill            <= '0;
            write_out.addr  <= addr_t'(MAX_ADDR - 1);  // first write wraps to 0
            write_out.wr_en <= 1'b0;
        end else if (!rule_stall) begin
            fill           <= fill + LOG_WORD_SIZE'(NUM_PE);
            write_out.data <= {write_out.data[WORD_SIZE-NUM_PE-1:0], cells};
            if (fill == LOG_WORD_SIZE'(WORD_SIZE - NUM_PE)) begin
                write_out.wr_en <= 1'b1;  // word full
                write_out.addr  <= write_out.addr + 1'b1;
            end else begin
                write_out.wr_en <= 1'b0;
            end
        end else begin
            write_out.wr_en <= 1'b0;
        end
        pack_done <= rule_done;
    end

endmodule

// File: source/cell_rule_array.sv
`timescale 1ns/10ps

module cell_rule_array
    import life_geometry_pkg::*;
    import life_control_pkg::*;
(
    input  logic        clk_in,
    input  fetch_item_t item,
    input  logic        stall,
    input  logic        fetch_done,
    input  logic        evolve,
    input  cursor_t     cursor_in,
    output cells_t      cells,
    output logic        rule_stall,
    output logic        rule_done
);

    cells_t     old_cells;
    cells_t     next_cells;
    logic [3:0] live_nbrs [NUM_PE];
    pos_t       cell_x    [NUM_PE];

    // cells bit i sits at window column i+1
    always_comb begin
        for (int i = 0; i < NUM_PE; i++) begin
            old_cells[i] = item.window.center[i+1];
            live_nbrs[i] = 4'(item.window.above[i+2]) + 4'(item.window.above[i+1])
                         + 4'(item.window.above[i])   + 4'(item.window.center[i+2])
                         + 4'(item.window.center[i])  + 4'(item.window.below[i+2])
                         + 4'(item.window.below[i+1]) + 4'(item.window.below[i]);
            cell_x[i]    = item.x + pos_t'(NUM_PE - 1 - i);

            if (cursor_in.click && cell_x[i] == cursor_in.x && item.y == cursor_in.y) begin
                next_cells[i] = !old_cells[i];  // click wins over the rule
            end else if (!evolve) begin
                next_cells[i] = old_cells[i];   // copy pass
            end else if (old_cells[i]) begin
                next_cells[i] = live_nbrs[i] == 4'd2 || live_nbrs[i] == 4'd3;
            end else begin
                next_cells[i] = live_nbrs[i] == 4'd3;  // birth
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (!stall) begin
            cells <= next_cells;
        end
        rule_stall <= stall;
        rule_done  <= fetch_done;
    end

endmodule

// File: source/window_fetcher.sv
`timescale 1ns/10ps

module window_fetcher
    import life_geometry_pkg::*;
(
    input  logic        clk_in,
    input  logic        start_in,
    input  word_t       data_r_in,
    output addr_t       addr_r_out,
    output fetch_item_t item,
    output logic        stall,
    output logic        fetch_done
);

    typedef enum logic [2:0] {
        SEARCH,
        PRE_FETCH,
        FETCH_ROW_0,
        FETCH_ROW_1,
        FETCH_ROW_2,
        FETCH_ROW_3,
        FETCH_ROW_4,
        FETCH_ROW_5
    } cache_state_t;

    cache_state_t           state;
    logic                   busy;         // scan in progress
    logic                   item_valid;   // item holds a finished window
    logic                   cache_valid;
    pos_t                   tag_y;        // centre row held in line_buf
    word_col_t              tag_col;      // left word column held in line_buf
    logic [2*WORD_SIZE-1:0] line_buf [3]; // above, centre, below, left word on top

    logic [LOG_BOARD_SIZE:0]  left_col;   // column x-1, -1 at the left edge
    word_col_t                lw;
    logic [LOG_WORD_SIZE-1:0] offset;     // x-1 inside the left word
    logic                     cache_hit;
    logic                     last_x;
    logic                     last_y;
    logic [2:0]               fill_slot;

    // slots 0..2 are the left word of rows y-1..y+1, slots 3..5 the right word
    function automatic addr_t slot_addr(input pos_t row_y, input word_col_t col,
                                        input logic [2:0] slot);
        pos_t      r;
        word_col_t c;
        r = row_y + pos_t'(slot % 3) - pos_t'(1);
        c = (slot < 3'd3) ? col : col + word_col_t'(1);
        return addr_t'(r * WORDS_PER_ROW) + addr_t'(c);
    endfunction

    // true when the slot lies outside the board and must read as dead
    function automatic logic slot_blank(input pos_t row_y, input word_col_t col,
                                        input logic [2:0] slot);
        logic row_out;
        logic col_out;
        row_out = (slot % 3 == 0 && row_y == '0)
               || (slot % 3 == 2 && row_y == pos_t'(BOARD_SIZE - 1));
        col_out = (slot < 3'd3) ? (col < 0) : (col == word_col_t'(WORDS_PER_ROW - 1));
        return row_out || col_out;
    endfunction

    function automatic win_row_t window_row(input logic [2*WORD_SIZE-1:0] line,
                                            input logic [LOG_WORD_SIZE-1:0] off);
        return line[2*WORD_SIZE-1-off -: WINDOW_WIDTH];
    endfunction

    assign left_col   = {1'b0, item.x} - 1'b1;
    assign lw         = word_col_t'(left_col[LOG_BOARD_SIZE:LOG_WORD_SIZE]);
    assign offset     = left_col[LOG_WORD_SIZE-1:0];
    assign cache_hit  = cache_valid && tag_y == item.y && tag_col == lw;
    assign last_x     = item.x == pos_t'(BOARD_SIZE - NUM_PE);
    assign last_y     = item.y == pos_t'(BOARD_SIZE - 1);
    assign fill_slot  = 3'(state) - 3'(FETCH_ROW_0);
    assign stall      = !item_valid;
    assign fetch_done = !busy;

    always_ff @(posedge clk_in) begin
        if (start_in) begin
            item.x      <= '0;
            item.y      <= '0;
            busy        <= 1'b1;
            item_valid  <= 1'b0;
            cache_valid <= 1'b0;  // new board in memory
            state       <= SEARCH;
        end else if (busy && item_valid) begin
            item_valid <= 1'b0;   // taken by the rule stage, step the scan
            if (!last_x) begin
                item.x <= item.x + pos_t'(NUM_PE);
            end else begin
                item.x <= '0;
                if (last_y) begin
                    busy <= 1'b0;
                end else begin
                    item.y <= item.y + 1'b1;
                end
            end
        end else if (busy) begin
            case (state)
                SEARCH: begin
                    if (cache_hit) begin
                        item.window.above  <= window_row(line_buf[0], offset);
                        item.window.center <= window_row(line_buf[1], offset);
                        item.window.below  <= window_row(line_buf[2], offset);
                        item_valid         <= 1'b1;
                    end else begin
                        tag_y       <= item.y;
                        tag_col     <= lw;
                        cache_valid <= 1'b0;
                        addr_r_out  <= slot_addr(item.y, lw, 3'd0);
                        state       <= PRE_FETCH;
                    end
                end
                PRE_FETCH: begin  // memory latency
                    addr_r_out <= slot_addr(item.y, lw, 3'd1);
                    state      <= FETCH_ROW_0;
                end
                default: begin
                    // word for slot n arrives in FETCH_ROW_n
                    line_buf[fill_slot % 3][(fill_slot < 3'd3 ? WORD_SIZE : 0) +: WORD_SIZE]
                        <= slot_blank(item.y, lw, fill_slot) ? '0 : data_r_in;
                    if (fill_slot < 3'd4) begin
                        addr_r_out <= slot_addr(item.y, lw, fill_slot + 3'd2);
                    end
                    if (state == FETCH_ROW_5) begin
                        cache_valid <= 1'b1;
                        state       <= SEARCH;
                    end else begin
                        state <= cache_state_t'(state + 1'b1);
                    end
                end
            endcase
        end
    end

endmodule

// File: source/step_control.sv
`timescale 1ns/10ps

module step_control
    import life_control_pkg::*;
(
    input  logic   clk_in,
    input  logic   rst_in,
    input  logic   start_in,
    input  speed_t speed_in,
    input  logic   pack_done,
    output logic   evolve,
    output logic   wb_start,
    output logic   done_out
);

    speed_t accum;    // fractional generation counter
    logic   start_d;  // first stage of the packer start delay
    logic   go;

    assign go = start_in && done_out;  // ignore start while a pass runs

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            accum    <= '0;
            evolve   <= 1'b0;
            start_d  <= 1'b0;
            wb_start <= 1'b0;
            done_out <= 1'b1;
        end else begin
            start_d  <= go;
            wb_start <= start_d;
            if (go) begin
                // held for the whole pass
                evolve   <= accum >= {SPEED_WIDTH{1'b1}} - speed_in;
                accum    <= accum + speed_in;  // wraps at 256
                done_out <= 1'b0;
            end else if (pack_done && !start_d && !wb_start) begin
                // pack_done is stale until the packer has been restarted
                done_out <= 1'b1;
            end
        end
    end

endmodule

// File: source/life_control_pkg.sv
package life_control_pkg;

    import life_geometry_pkg::*;

    localparam int SPEED_WIDTH = 8;

    typedef logic [SPEED_WIDTH-1:0] speed_t;

    typedef struct packed {
        pos_t x;
        pos_t y;
        logic click;  // toggle the named cell this pass
    } cursor_t;

    typedef struct packed {
        addr_t addr;
        word_t data;
        logic  wr_en;
    } mem_write_t;

endpackage

// File: source/life_geometry_pkg.sv
package life_geometry_pkg;

    localparam int BOARD_SIZE     = 16;  // cells per side
    localparam int LOG_BOARD_SIZE = 4;
    localparam int WORD_SIZE      = 8;   // cells per memory word
    localparam int LOG_WORD_SIZE  = 3;
    localparam int WORDS_PER_ROW  = BOARD_SIZE / WORD_SIZE;
    localparam int MAX_ADDR       = BOARD_SIZE * WORDS_PER_ROW;
    localparam int LOG_MAX_ADDR   = 5;
    localparam int NUM_PE         = 2;   // cells computed per step
    localparam int WINDOW_WIDTH   = NUM_PE + 2;

    // msb is always the leftmost cell
    typedef logic [LOG_BOARD_SIZE-1:0] pos_t;
    typedef logic [LOG_MAX_ADDR-1:0]   addr_t;
    typedef logic [WORD_SIZE-1:0]      word_t;
    typedef logic [NUM_PE-1:0]         cells_t;
    typedef logic [WINDOW_WIDTH-1:0]   win_row_t;

    // word column inside a board row, -1 is the dead word left of the board
    typedef logic signed [LOG_BOARD_SIZE-LOG_WORD_SIZE:0] word_col_t;

    typedef struct packed {
        win_row_t above;
        win_row_t center;
        win_row_t below;
    } window_t;

    typedef struct packed {
        pos_t    x;       // leftmost cell of the group
        pos_t    y;
        window_t window;
    } fetch_item_t;

endpackage
